/* hdl/adpbc_edge_detect.sv */
//--------------------
// Edge detector for a vector of comparator and session levels.
// Samples the vector on every upclk edge and gives one-cycle rise and
// fall pulses per bit. A bit only pulses when its qualify bit is set at
// the edge that sees the change. Set sample_t to the vector type.
//--------------------
`default_nettype none

module adpbc_edge_detect #(
  parameter type sample_t = logic
) (
  input  logic    upclk,
  input  logic    rst_n,
  input  sample_t sample,
  input  sample_t qualify,
  output sample_t rise,
  output sample_t fall
);

  // Level seen at the previous edge
  sample_t sample_q;

  always_ff @(posedge upclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_q <= '0;
      rise     <= '0;
      fall     <= '0;
    end
    else
    begin
      sample_q <= sample;
      rise     <= sample & ~sample_q & qualify;
      fall     <= ~sample & sample_q & qualify;
    end
  end

  //--------------------
  // Checks
  //--------------------

  // Rise and fall never share a cycle on any bit
  a_rise_fall_excl: assert property (
    @(posedge upclk) disable iff (!rst_n)
    (rise & fall) == '0
  );

endmodule

`default_nettype wire

/* hdl/adpbc_id_status.sv */
//--------------------
// ID classification latch and status word assembly.
// Takes the qualified ID rise pulses and the raw levels, tracks which
// ID resistor was last detected, and builds the three status words.
// Status word 2 tracks the class in the same cycle as the rise pulse.
//--------------------
`default_nettype none

module adpbc_id_status (
  input  logic                        upclk,
  input  logic                        rst_n,
  input  adpbc_sense_pkg::rid_sense_t rid_rise,
  input  adpbc_sense_pkg::rid_sense_t rid_level,
  input  adpbc_sense_pkg::adp_sense_t adp_level,
  input  logic [1:0]                  linestate,
  input  logic                        rid_float_comp_en,
  input  logic                        rid_nonfloat_comp_en,
  output adpbc_reg_pkg::stat0_t       adpbc_status_0,
  output adpbc_reg_pkg::stat1_t       adpbc_status_1,
  output adpbc_reg_pkg::stat2_t       adpbc_status_2
);

  import adpbc_sense_pkg::*;

  rid_state_t rid_state_q;
  rid_state_t rid_state;
  logic       float_hit_q;
  logic       nonfloat_en_q;

  // Float rule and enable taken at the same edge as the rise pulses
  always_ff @(posedge upclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      float_hit_q   <= 1'b0;
      nonfloat_en_q <= 1'b0;
      rid_state_q   <= rid_none;
    end
    else
    begin
      float_hit_q   <= rid_float_comp_en & ~rid_nonfloat_comp_en &
                       rid_level[rid_float_idx];
      nonfloat_en_q <= rid_nonfloat_comp_en;
      rid_state_q   <= rid_state;
    end
  end

  //--------------------
  // Classification
  //--------------------

  // Priority A, B, C, ground among simultaneous rises
  always_comb
  begin
    rid_state = rid_state_q;
    if (float_hit_q)
      rid_state = rid_is_float;
    else if (nonfloat_en_q)
    begin
      if (rid_rise[rid_a_idx])
        rid_state = rid_is_a;
      else if (rid_rise[rid_b_idx])
        rid_state = rid_is_b;
      else if (rid_rise[rid_c_idx])
        rid_state = rid_is_c;
      else if (rid_rise[rid_gnd_idx])
        rid_state = rid_is_gnd;
      else if (rid_state_q == rid_is_float)
        rid_state = rid_none;
    end
  end

  // One-hot view of the class in ID level bit order
  always_comb
  begin
    adpbc_status_2 = '0;
    case (rid_state)
      rid_is_a:     adpbc_status_2[rid_a_idx]     = 1'b1;
      rid_is_b:     adpbc_status_2[rid_b_idx]     = 1'b1;
      rid_is_c:     adpbc_status_2[rid_c_idx]     = 1'b1;
      rid_is_gnd:   adpbc_status_2[rid_gnd_idx]   = 1'b1;
      rid_is_float: adpbc_status_2[rid_float_idx] = 1'b1;
      default:      adpbc_status_2 = '0;
    endcase
  end

  assign adpbc_status_0 = adp_level;
  assign adpbc_status_1 = {linestate, 1'b0, rid_level};

  //--------------------
  // Checks
  //--------------------

  a_stat2_onehot: assert property (
    @(posedge upclk) disable iff (!rst_n)
    $onehot0(adpbc_status_2)
  );

endmodule

`default_nettype wire

/* hdl/adpbc_reg_pkg.sv */
//--------------------
// Register map of the ADP and battery charging sense block.
// Holds the control word widths, the bit position of every analog
// enable, and the control and status word types used at the top level.
//--------------------
`default_nettype none

package adpbc_reg_pkg;

  // Word widths
  localparam int ctrl0_w = 5;
  localparam int ctrl1_w = 6;
  localparam int ctrl2_w = 8;
  localparam int stat0_w = 8;
  localparam int stat1_w = 8;
  localparam int stat2_w = 5;

  // ADP analog controls in control word 0
  localparam int adp_en_bit                = 0;
  localparam int adp_probe_en_bit          = 1;
  localparam int adp_sense_en_bit          = 2;
  localparam int adp_sink_current_en_bit   = 3;
  localparam int adp_source_current_en_bit = 4;

  // Charger detect sources and sinks in control word 1
  localparam int bc_en_bit       = 0;
  localparam int idm_sink_en_bit = 1;
  localparam int idp_sink_en_bit = 2;
  localparam int idp_src_en_bit  = 3;
  localparam int vdm_src_en_bit  = 4;
  localparam int vdp_src_en_bit  = 5;

  // Comparator enables and pulldowns in control word 2
  localparam int dm_vdat_ref_comp_en_bit  = 0;
  localparam int dm_vlgc_comp_en_bit      = 1;
  localparam int dp_vdat_ref_comp_en_bit  = 2;
  localparam int rid_float_comp_en_bit    = 3;
  localparam int rid_nonfloat_comp_en_bit = 4;
  localparam int bc_dmpulldown_bit        = 5;
  localparam int bc_dppulldown_bit        = 6;
  localparam int bc_pulldownctrl_bit      = 7;

  typedef logic [ctrl0_w-1:0] ctrl0_t;
  typedef logic [ctrl1_w-1:0] ctrl1_t;
  typedef logic [ctrl2_w-1:0] ctrl2_t;
  typedef logic [stat0_w-1:0] stat0_t;
  typedef logic [stat1_w-1:0] stat1_t;
  typedef logic [stat2_w-1:0] stat2_t;

endpackage

`default_nettype wire

/* hdl/adpbc_sense_pkg.sv */
//--------------------
// Sense-side definitions of the ADP and battery charging block.
// The two sample vectors follow the bit order of status words 0 and 1,
// so a sample vector maps straight onto its status field.
// Also holds the encoding of the latched ID-resistor classification.
//--------------------
`default_nettype none

package adpbc_sense_pkg;

  localparam int adp_sense_w = 8;
  localparam int rid_sense_w = 5;

  // ADP, session and charger detect levels, status word 0 order
  localparam int sessend_idx      = 7;
  localparam int adp_sense_idx    = 6;
  localparam int adp_probe_idx    = 5;
  localparam int otgsessvalid_idx = 4;
  localparam int dcd_comp_idx     = 3;
  localparam int dm_vdat_idx      = 2;
  localparam int dm_vlgc_idx      = 1;
  localparam int dp_vdat_idx      = 0;

  typedef logic [adp_sense_w-1:0] adp_sense_t;

  // ID comparator levels, A first from the MSB
  localparam int rid_a_idx     = 4;
  localparam int rid_b_idx     = 3;
  localparam int rid_c_idx     = 2;
  localparam int rid_gnd_idx   = 1;
  localparam int rid_float_idx = 0;

  typedef logic [rid_sense_w-1:0] rid_sense_t;

  // Latched ID resistor class
  typedef enum logic [2:0] {
    rid_none,
    rid_is_a,
    rid_is_b,
    rid_is_c,
    rid_is_gnd,
    rid_is_float
  } rid_state_t;

endpackage

`default_nettype wire

/* hdl/adpbc_top.sv */
//--------------------
// Attach detection and battery charging sense block of the OTG core.
// Splits the control words into analog enables, turns the comparator
// and session levels into rise and fall pulses, and returns the status
// words to the register file.
//--------------------
`default_nettype none

module adpbc_top (
  input  logic                   upclk,
  input  logic                   rst_n,
  input  adpbc_reg_pkg::ctrl0_t  adpbc_ctrl_0,
  input  adpbc_reg_pkg::ctrl1_t  adpbc_ctrl_1,
  input  adpbc_reg_pkg::ctrl2_t  adpbc_ctrl_2,
  output adpbc_reg_pkg::stat0_t  adpbc_status_0,
  output adpbc_reg_pkg::stat1_t  adpbc_status_1,
  output adpbc_reg_pkg::stat2_t  adpbc_status_2,
  output logic                   adpbc_rid_float_fall,
  output logic                   adpbc_rid_float_rise,
  output logic                   adpbc_rid_gnd_rise,
  output logic                   adpbc_rid_c_rise,
  output logic                   adpbc_rid_b_rise,
  output logic                   adpbc_rid_a_rise,
  output logic                   adpbc_sessend_rise,
  output logic                   adpbc_otgsessvalid_rise,
  output logic                   adpbc_sense_rise,
  output logic                   adpbc_probe_rise,
  output logic                   dm_vdat_ref_rise,
  output logic                   dp_vdat_ref_rise,
  output logic                   dcd_comp_rise,
  output logic                   dcd_comp_fall,
  output logic                   dm_vlgc_comp_rise,
  output logic                   adp_en,
  output logic                   adp_probe_en,
  output logic                   adp_sense_en,
  output logic                   adp_sink_current_en,
  output logic                   adp_source_current_en,
  output logic                   bc_en,
  output logic                   dm_vdat_ref_comp_en,
  output logic                   dm_vlgc_comp_en,
  output logic                   dp_vdat_ref_comp_en,
  output logic                   idm_sink_en,
  output logic                   idp_sink_en,
  output logic                   idp_src_en,
  output logic                   vdm_src_en,
  output logic                   vdp_src_en,
  output logic                   rid_float_comp_en,
  output logic                   rid_nonfloat_comp_en,
  output logic                   bc_dmpulldown,
  output logic                   bc_dppulldown,
  output logic                   bc_pulldownctrl,
  input  logic                   sessend,
  input  logic                   otgsessvalid,
  input  logic [1:0]             linestate,
  input  logic                   adp_probe_ana,
  input  logic                   adp_sense_ana,
  input  logic                   dcd_comp_sts,
  input  logic                   dm_vdat_ref_comp_sts,
  input  logic                   dm_vlgc_comp_sts,
  input  logic                   dp_vdat_ref_comp_sts,
  input  logic                   rid_a_comp_sts,
  input  logic                   rid_b_comp_sts,
  input  logic                   rid_c_comp_sts,
  input  logic                   rid_float_comp_sts,
  input  logic                   rid_gnd_comp_sts
);

  import adpbc_reg_pkg::*;
  import adpbc_sense_pkg::*;

  adp_sense_t adp_level;
  adp_sense_t adp_rise;
  adp_sense_t adp_fall;
  rid_sense_t rid_level;
  rid_sense_t rid_qual;
  rid_sense_t rid_rise;
  rid_sense_t rid_fall;

  //--------------------
  // Control decode
  //--------------------
  assign adp_en                = adpbc_ctrl_0[adp_en_bit];
  assign adp_probe_en          = adpbc_ctrl_0[adp_probe_en_bit];
  assign adp_sense_en          = adpbc_ctrl_0[adp_sense_en_bit];
  assign adp_sink_current_en   = adpbc_ctrl_0[adp_sink_current_en_bit];
  assign adp_source_current_en = adpbc_ctrl_0[adp_source_current_en_bit];

  assign bc_en                 = adpbc_ctrl_1[bc_en_bit];
  assign idm_sink_en           = adpbc_ctrl_1[idm_sink_en_bit];
  assign idp_sink_en           = adpbc_ctrl_1[idp_sink_en_bit];
  assign idp_src_en            = adpbc_ctrl_1[idp_src_en_bit];
  assign vdm_src_en            = adpbc_ctrl_1[vdm_src_en_bit];
  assign vdp_src_en            = adpbc_ctrl_1[vdp_src_en_bit];

  assign dm_vdat_ref_comp_en   = adpbc_ctrl_2[dm_vdat_ref_comp_en_bit];
  assign dm_vlgc_comp_en       = adpbc_ctrl_2[dm_vlgc_comp_en_bit];
  assign dp_vdat_ref_comp_en   = adpbc_ctrl_2[dp_vdat_ref_comp_en_bit];
  assign rid_float_comp_en     = adpbc_ctrl_2[rid_float_comp_en_bit];
  assign rid_nonfloat_comp_en  = adpbc_ctrl_2[rid_nonfloat_comp_en_bit];
  assign bc_dmpulldown         = adpbc_ctrl_2[bc_dmpulldown_bit];
  assign bc_dppulldown         = adpbc_ctrl_2[bc_dppulldown_bit];
  assign bc_pulldownctrl       = adpbc_ctrl_2[bc_pulldownctrl_bit];

  //--------------------
  // Sense vectors
  //--------------------
  assign adp_level[sessend_idx]      = sessend;
  assign adp_level[adp_sense_idx]    = adp_sense_ana;
  assign adp_level[adp_probe_idx]    = adp_probe_ana;
  assign adp_level[otgsessvalid_idx] = otgsessvalid;
  assign adp_level[dcd_comp_idx]     = dcd_comp_sts;
  assign adp_level[dm_vdat_idx]      = dm_vdat_ref_comp_sts;
  assign adp_level[dm_vlgc_idx]      = dm_vlgc_comp_sts;
  assign adp_level[dp_vdat_idx]      = dp_vdat_ref_comp_sts;

  assign rid_level[rid_a_idx]     = rid_a_comp_sts;
  assign rid_level[rid_b_idx]     = rid_b_comp_sts;
  assign rid_level[rid_c_idx]     = rid_c_comp_sts;
  assign rid_level[rid_gnd_idx]   = rid_gnd_comp_sts;
  assign rid_level[rid_float_idx] = rid_float_comp_sts;

  // ID pulses only while the matching comparator is powered
  assign rid_qual[rid_a_idx]     = rid_nonfloat_comp_en;
  assign rid_qual[rid_b_idx]     = rid_nonfloat_comp_en;
  assign rid_qual[rid_c_idx]     = rid_nonfloat_comp_en;
  assign rid_qual[rid_gnd_idx]   = rid_nonfloat_comp_en;
  assign rid_qual[rid_float_idx] = rid_float_comp_en;

  adpbc_edge_detect #(
    .sample_t (adp_sense_t)
  ) adp_edges (
    .upclk   (upclk),
    .rst_n   (rst_n),
    .sample  (adp_level),
    .qualify ('1),
    .rise    (adp_rise),
    .fall    (adp_fall)
  );

  adpbc_edge_detect #(
    .sample_t (rid_sense_t)
  ) rid_edges (
    .upclk   (upclk),
    .rst_n   (rst_n),
    .sample  (rid_level),
    .qualify (rid_qual),
    .rise    (rid_rise),
    .fall    (rid_fall)
  );

  adpbc_id_status u_id_status (
    .upclk                (upclk),
    .rst_n                (rst_n),
    .rid_rise             (rid_rise),
    .rid_level            (rid_level),
    .adp_level            (adp_level),
    .linestate            (linestate),
    .rid_float_comp_en    (rid_float_comp_en),
    .rid_nonfloat_comp_en (rid_nonfloat_comp_en),
    .adpbc_status_0       (adpbc_status_0),
    .adpbc_status_1       (adpbc_status_1),
    .adpbc_status_2       (adpbc_status_2)
  );

  //--------------------
  // Pulse outputs
  //--------------------
  assign adpbc_sessend_rise      = adp_rise[sessend_idx];
  assign adpbc_sense_rise        = adp_rise[adp_sense_idx];
  assign adpbc_probe_rise        = adp_rise[adp_probe_idx];
  assign adpbc_otgsessvalid_rise = adp_rise[otgsessvalid_idx];
  assign dcd_comp_rise           = adp_rise[dcd_comp_idx];
  assign dcd_comp_fall           = adp_fall[dcd_comp_idx];
  assign dm_vdat_ref_rise        = adp_rise[dm_vdat_idx];
  assign dm_vlgc_comp_rise       = adp_rise[dm_vlgc_idx];
  assign dp_vdat_ref_rise        = adp_rise[dp_vdat_idx];

  assign adpbc_rid_a_rise        = rid_rise[rid_a_idx];
  assign adpbc_rid_b_rise        = rid_rise[rid_b_idx];
  assign adpbc_rid_c_rise        = rid_rise[rid_c_idx];
  assign adpbc_rid_gnd_rise      = rid_rise[rid_gnd_idx];
  assign adpbc_rid_float_rise    = rid_rise[rid_float_idx];
  assign adpbc_rid_float_fall    = rid_fall[rid_float_idx];

endmodule

`default_nettype wire

/* list.f */
hdl/adpbc_reg_pkg.sv
hdl/adpbc_sense_pkg.sv
hdl/adpbc_edge_detect.sv
hdl/adpbc_id_status.sv
hdl/adpbc_top.sv
tests/tb_adpbc.sv

/* run.sh */
#!/bin/sh
# Build and run the ADP/BC sense testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_adpbc \
  -Mdir obj_dir -o tb_adpbc
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_adpbc > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test FAILED" "$log"; then
  echo "Simulation reported a failure, see $log"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

/* tests/adpbc_golden.txt */
# One vector per cycle, hex: ctrl0 ctrl1 ctrl2 adp_in rid_in linestate, then expected
# status0 status1 status2 adp_rise adp_fall rid_rise rid_fall en0 en1 en2
00 00 00 00 00 0  00 00 00  00 00 00 00  00 00 00
15 2a a5 00 00 1  00 40 00  00 00 00 00  15 2a a5
0a 15 47 80 00 2  80 80 00  00 00 00 00  0a 15 47
00 00 00 80 00 3  80 c0 00  80 00 00 00  00 00 00
00 00 00 80 00 0  80 00 00  00 00 00 00  00 00 00
00 00 00 c8 00 0  c8 00 00  00 00 00 00  00 00 00
00 00 00 88 00 0  88 00 00  48 00 00 00  00 00 00
00 00 00 80 00 0  80 00 00  00 00 00 00  00 00 00
1f 3f e7 37 00 0  37 00 00  00 08 00 00  1f 3f e7
00 00 00 00 00 0  00 00 00  37 00 00 00  00 00 00
00 00 00 00 1c 0  00 1c 00  00 00 00 00  00 00 00
00 00 00 00 1d 0  00 1d 00  00 00 00 00  00 00 00
00 00 00 00 1c 0  00 1c 00  00 00 00 00  00 00 00
00 00 00 00 00 0  00 00 00  00 00 00 00  00 00 00
00 00 10 00 00 0  00 00 00  00 00 00 00  00 00 10
00 00 10 00 0c 0  00 0c 00  00 00 00 00  00 00 10
00 00 10 00 0c 0  00 0c 08  00 00 0c 00  00 00 10
00 00 10 00 0c 1  00 4c 08  00 00 00 00  00 00 10
00 00 10 00 0e 0  00 0e 08  00 00 00 00  00 00 10
00 00 10 00 0e 0  00 0e 02  00 00 02 00  00 00 10
00 00 10 00 00 0  00 00 02  00 00 00 00  00 00 10
00 00 08 00 01 0  00 01 02  00 00 00 00  00 00 08
00 00 08 00 01 3  00 c1 01  00 00 01 00  00 00 08
00 00 08 00 00 0  00 00 01  00 00 00 00  00 00 08
00 00 08 00 00 0  00 00 01  00 00 00 01  00 00 08
00 00 10 00 00 0  00 00 01  00 00 00 00  00 00 10
00 00 10 00 00 0  00 00 00  00 00 00 00  00 00 10
00 00 00 00 00 0  00 00 00  00 00 00 00  00 00 00

/* tests/tb_adpbc.sv */
//--------------------
// Testbench for the ADP and battery charging sense block.
// Replays tests/adpbc_golden.txt one vector per upclk cycle. Inputs are
// driven just after the rising edge and every output is checked just
// before the next one. The run stops at the first mismatch.
//--------------------
`default_nettype none

module tb_adpbc;

  import adpbc_reg_pkg::*;
  import adpbc_sense_pkg::*;

  localparam int reset_timeout = 8;
  localparam int vector_limit  = 200;

  logic       upclk;
  logic       rst_n;
  ctrl0_t     adpbc_ctrl_0;
  ctrl1_t     adpbc_ctrl_1;
  ctrl2_t     adpbc_ctrl_2;
  stat0_t     adpbc_status_0;
  stat1_t     adpbc_status_1;
  stat2_t     adpbc_status_2;
  logic [1:0] linestate;

  // Pulse outputs
  logic adpbc_rid_float_fall, adpbc_rid_float_rise, adpbc_rid_gnd_rise;
  logic adpbc_rid_c_rise, adpbc_rid_b_rise, adpbc_rid_a_rise;
  logic adpbc_sessend_rise, adpbc_otgsessvalid_rise, adpbc_sense_rise, adpbc_probe_rise;
  logic dm_vdat_ref_rise, dp_vdat_ref_rise, dcd_comp_rise, dcd_comp_fall, dm_vlgc_comp_rise;

  // Analog enables
  logic adp_en, adp_probe_en, adp_sense_en, adp_sink_current_en, adp_source_current_en;
  logic bc_en, idm_sink_en, idp_sink_en, idp_src_en, vdm_src_en, vdp_src_en;
  logic dm_vdat_ref_comp_en, dm_vlgc_comp_en, dp_vdat_ref_comp_en;
  logic rid_float_comp_en, rid_nonfloat_comp_en, bc_dmpulldown, bc_dppulldown, bc_pulldownctrl;

  // Comparator and session levels
  logic sessend, otgsessvalid, adp_probe_ana, adp_sense_ana;
  logic dcd_comp_sts, dm_vdat_ref_comp_sts, dm_vlgc_comp_sts, dp_vdat_ref_comp_sts;
  logic rid_a_comp_sts, rid_b_comp_sts, rid_c_comp_sts, rid_float_comp_sts, rid_gnd_comp_sts;

  adpbc_top DUT (.*);

  initial
  begin
    upclk = 1'b0;
    forever #2 upclk = ~upclk;
  end

  //--------------------
  // Helpers
  //--------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    abort_run($sformatf("** Error at time %0t: %s expected %s, got %s",
                        $time, name, exp_s, act_s));
  endtask

  task automatic apply_inputs(input ctrl0_t c0, input ctrl1_t c1, input ctrl2_t c2,
                              input adp_sense_t adp, input rid_sense_t rid,
                              input logic [1:0] ls);
    adpbc_ctrl_0         = c0;
    adpbc_ctrl_1         = c1;
    adpbc_ctrl_2         = c2;
    sessend              = adp[sessend_idx];
    adp_sense_ana        = adp[adp_sense_idx];
    adp_probe_ana        = adp[adp_probe_idx];
    otgsessvalid         = adp[otgsessvalid_idx];
    dcd_comp_sts         = adp[dcd_comp_idx];
    dm_vdat_ref_comp_sts = adp[dm_vdat_idx];
    dm_vlgc_comp_sts     = adp[dm_vlgc_idx];
    dp_vdat_ref_comp_sts = adp[dp_vdat_idx];
    rid_a_comp_sts       = rid[rid_a_idx];
    rid_b_comp_sts       = rid[rid_b_idx];
    rid_c_comp_sts       = rid[rid_c_idx];
    rid_gnd_comp_sts     = rid[rid_gnd_idx];
    rid_float_comp_sts   = rid[rid_float_idx];
    linestate            = ls;
  endtask

  // Scattered pulse outputs gathered into sense vectors
  function automatic adp_sense_t adp_rise_seen();
    adp_sense_t v;
    v = '0;
    v[sessend_idx]      = adpbc_sessend_rise;
    v[adp_sense_idx]    = adpbc_sense_rise;
    v[adp_probe_idx]    = adpbc_probe_rise;
    v[otgsessvalid_idx] = adpbc_otgsessvalid_rise;
    v[dcd_comp_idx]     = dcd_comp_rise;
    v[dm_vdat_idx]      = dm_vdat_ref_rise;
    v[dm_vlgc_idx]      = dm_vlgc_comp_rise;
    v[dp_vdat_idx]      = dp_vdat_ref_rise;
    return v;
  endfunction

  function automatic rid_sense_t rid_rise_seen();
    rid_sense_t v;
    v = '0;
    v[rid_a_idx]     = adpbc_rid_a_rise;
    v[rid_b_idx]     = adpbc_rid_b_rise;
    v[rid_c_idx]     = adpbc_rid_c_rise;
    v[rid_gnd_idx]   = adpbc_rid_gnd_rise;
    v[rid_float_idx] = adpbc_rid_float_rise;
    return v;
  endfunction

  //--------------------
  // Compare tasks
  //--------------------
  task automatic check_stat0(input stat0_t exp, input stat0_t act, input string name);
    if (act !== exp)
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_stat1(input stat1_t exp, input stat1_t act, input string name);
    if (act !== exp)
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_stat2(input stat2_t exp, input stat2_t act, input string name);
    if (act !== exp)
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_adp_pulses(input adp_sense_t exp, input adp_sense_t act,
                                  input string name);
    if (act !== exp)
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_rid_pulses(input rid_sense_t exp, input rid_sense_t act,
                                  input string name);
    if (act !== exp)
      report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_enables(input ctrl0_t exp0, input ctrl1_t exp1, input ctrl2_t exp2);
    ctrl0_t act0;
    ctrl1_t act1;
    ctrl2_t act2;
    act0 = '0;
    act1 = '0;
    act2 = '0;
    act0[adp_en_bit]                = adp_en;
    act0[adp_probe_en_bit]          = adp_probe_en;
    act0[adp_sense_en_bit]          = adp_sense_en;
    act0[adp_sink_current_en_bit]   = adp_sink_current_en;
    act0[adp_source_current_en_bit] = adp_source_current_en;
    act1[bc_en_bit]                 = bc_en;
    act1[idm_sink_en_bit]           = idm_sink_en;
    act1[idp_sink_en_bit]           = idp_sink_en;
    act1[idp_src_en_bit]            = idp_src_en;
    act1[vdm_src_en_bit]            = vdm_src_en;
    act1[vdp_src_en_bit]            = vdp_src_en;
    act2[dm_vdat_ref_comp_en_bit]   = dm_vdat_ref_comp_en;
    act2[dm_vlgc_comp_en_bit]       = dm_vlgc_comp_en;
    act2[dp_vdat_ref_comp_en_bit]   = dp_vdat_ref_comp_en;
    act2[rid_float_comp_en_bit]     = rid_float_comp_en;
    act2[rid_nonfloat_comp_en_bit]  = rid_nonfloat_comp_en;
    act2[bc_dmpulldown_bit]         = bc_dmpulldown;
    act2[bc_dppulldown_bit]         = bc_dppulldown;
    act2[bc_pulldownctrl_bit]       = bc_pulldownctrl;
    if (act0 !== exp0)
      report_mismatch("enables of adpbc_ctrl_0", $sformatf("%h", exp0), $sformatf("%h", act0));
    if (act1 !== exp1)
      report_mismatch("enables of adpbc_ctrl_1", $sformatf("%h", exp1), $sformatf("%h", act1));
    if (act2 !== exp2)
      report_mismatch("enables of adpbc_ctrl_2", $sformatf("%h", exp2), $sformatf("%h", act2));
  endtask

  //--------------------
  // Main sequence
  //--------------------
  initial
  begin
    int         fd;
    int         fields;
    int         vectors;
    int         waited;
    string      line;
    ctrl0_t     c0;
    ctrl1_t     c1;
    ctrl2_t     c2;
    adp_sense_t adp_in;
    rid_sense_t rid_in;
    logic [1:0] ls_in;
    stat0_t     exp_st0;
    stat1_t     exp_st1;
    stat2_t     exp_st2;
    adp_sense_t exp_adp_rise;
    adp_sense_t exp_adp_fall;
    rid_sense_t exp_rid_rise;
    rid_sense_t exp_rid_fall;
    ctrl0_t     exp_en0;
    ctrl1_t     exp_en1;
    ctrl2_t     exp_en2;

    rst_n = 1'b0;
    apply_inputs('0, '0, '0, '0, '0, 2'b00);
    repeat (2) @(posedge upclk);
    #1 rst_n = 1'b1;

    // Registered outputs must come out of reset cleared
    waited = 0;
    while (adpbc_status_2 !== '0 || adp_rise_seen() !== '0 || rid_rise_seen() !== '0)
    begin
      if (waited == reset_timeout)
        abort_run("Registered outputs did not clear after reset release");
      @(posedge upclk);
      #1;
      waited++;
    end

    fd = $fopen("tests/adpbc_golden.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the golden vector file tests/adpbc_golden.txt");

    vectors = 0;
    while ($fgets(line, fd) != 0)
    begin
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       c0, c1, c2, adp_in, rid_in, ls_in, exp_st0, exp_st1, exp_st2,
                       exp_adp_rise, exp_adp_fall, exp_rid_rise, exp_rid_fall,
                       exp_en0, exp_en1, exp_en2);
      // Comment and blank lines match no field
      if (fields > 0)
      begin
        if (fields != 16)
          abort_run({"Golden line does not hold 16 fields: ", line});
        if (vectors == vector_limit)
          abort_run("Golden file holds more vectors than the run allows");
        @(posedge upclk);
        #1;
        apply_inputs(c0, c1, c2, adp_in, rid_in, ls_in);
        #2;
        check_stat0(exp_st0, adpbc_status_0, "adpbc_status_0");
        check_stat1(exp_st1, adpbc_status_1, "adpbc_status_1");
        check_stat2(exp_st2, adpbc_status_2, "adpbc_status_2");
        check_adp_pulses(exp_adp_rise, adp_rise_seen(), "adp rise pulses");
        check_adp_pulses(exp_adp_fall, {4'b0000, dcd_comp_fall, 3'b000}, "dcd_comp_fall");
        check_rid_pulses(exp_rid_rise, rid_rise_seen(), "rid rise pulses");
        check_rid_pulses(exp_rid_fall, {4'b0000, adpbc_rid_float_fall}, "adpbc_rid_float_fall");
        check_enables(exp_en0, exp_en1, exp_en2);
        vectors++;
      end
    end
    $fclose(fd);

    if (vectors == 0)
      abort_run("Golden file holds no vectors");
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire
